// ==== src/cpu_cfg.svh ====
// Core configuration constants
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------

// Address bus, full 64K map
`define CPU_ADDR_W 16

// Data bus, one byte per access
`define CPU_DATA_W 8

// ----------------------------------------
// Reset behaviour
// ----------------------------------------

// Vector high byte lives here
// Low byte follows at the next address, big-endian
`define CPU_RESET_VECTOR 16'hFFFE

// E, F and I set out of reset
// N, Z, V, C and H clear
`define CPU_CC_RESET 8'hD0

`endif

// ==== src/cpu_types_pkg.sv ====
// Core bus and pipeline types
`include "cpu_cfg.svh"

package cpu_types_pkg;

  // ----------------------------------------
  // Bus types
  // ----------------------------------------

  // Memory address
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

  // Data byte, also used for A, B and CC
  typedef logic [`CPU_DATA_W-1:0] byte_t;

  // ----------------------------------------
  // Fetch FSM
  // ----------------------------------------

  typedef enum logic [1:0] {
    fetch_reset,   // Parked during reset
    fetch_vec_hi,  // Reading FFFE
    fetch_vec_lo,  // Reading FFFF
    fetch_opcode   // One opcode per cycle
  } fetch_state_t;

  // ----------------------------------------
  // Inter-module structs
  // ----------------------------------------

  // Fetch to ALU
  typedef struct packed {
    logic  valid;
    byte_t opcode;
  } issue_t;

  // Architectural registers as seen by the ALU
  typedef struct packed {
    byte_t a;
    byte_t b;
    byte_t cc;
  } arch_state_t;

  // ALU to register file
  typedef struct packed {
    logic  valid;
    byte_t opcode;
    logic  write_a;
    logic  write_b;
    byte_t result;
    byte_t cc;
  } writeback_t;

  // Retirement record, post-instruction values
  typedef struct packed {
    byte_t opcode;
    byte_t a;
    byte_t b;
    byte_t cc;
  } trace_t;

endpackage

// ==== src/m6809_isa_pkg.sv ====
// 6809 instruction set subset
package m6809_isa_pkg;

  // ----------------------------------------
  // Condition codes
  // ----------------------------------------

  // Full CC register
  typedef logic [7:0] cc_t;

  // Bit positions
  localparam int CC_E = 7;  // Entire state saved
  localparam int CC_F = 6;  // FIRQ mask
  localparam int CC_H = 5;  // Half carry
  localparam int CC_I = 4;  // IRQ mask
  localparam int CC_N = 3;  // Negative
  localparam int CC_Z = 2;  // Zero
  localparam int CC_V = 1;  // Overflow
  localparam int CC_C = 0;  // Carry

  // ----------------------------------------
  // Inherent accumulator opcodes
  // ----------------------------------------

  // Row 4x works on A, row 5x on B
  // Low nibble picks the operation
  localparam logic [7:0] OP_CLRA = 8'h4F;
  localparam logic [7:0] OP_CLRB = 8'h5F;

  localparam logic [7:0] OP_INCA = 8'h4C;
  localparam logic [7:0] OP_INCB = 8'h5C;

  localparam logic [7:0] OP_COMA = 8'h43;
  localparam logic [7:0] OP_COMB = 8'h53;

  // ASL and LSL share an encoding
  localparam logic [7:0] OP_ASLA = 8'h48;
  localparam logic [7:0] OP_ASLB = 8'h58;

  localparam logic [7:0] OP_ASRA = 8'h47;
  localparam logic [7:0] OP_ASRB = 8'h57;

  localparam logic [7:0] OP_LSRA = 8'h44;
  localparam logic [7:0] OP_LSRB = 8'h54;

  // ----------------------------------------
  // ALU operations
  // ----------------------------------------

  typedef enum logic [2:0] {
    alu_none,  // Retire as no-op
    alu_clr,
    alu_inc,
    alu_com,
    alu_asl,
    alu_asr,
    alu_lsr
  } alu_op_t;

endpackage

// ==== src/fetch_sequencer.sv ====
// Reset vector and opcode fetch
`include "cpu_cfg.svh"

module fetch_sequencer (
  input  logic                  clk,
  input  logic                  reset_b,
  input  logic                  halt_b,
  input  cpu_types_pkg::byte_t  data_in,
  output cpu_types_pkg::addr_t  addr,
  output cpu_types_pkg::issue_t issue
);

  // ----------------------------------------
  // State
  // ----------------------------------------

  cpu_types_pkg::fetch_state_t state_q;
  cpu_types_pkg::fetch_state_t state_nxt;

  // Program counter, doubles as the bus address
  cpu_types_pkg::addr_t pc_q;
  cpu_types_pkg::addr_t pc_nxt;

  // Vector high byte, held until the low byte arrives
  cpu_types_pkg::byte_t vec_hi_q;

  // Issue register
  cpu_types_pkg::byte_t opcode_q;
  logic                 issue_valid_q;

  // Opcode accepted this cycle
  logic take_opcode;

  // halt_b only gates opcode fetches
  assign take_opcode = (state_q == cpu_types_pkg::fetch_opcode) && halt_b;

  // ----------------------------------------
  // Next state and PC
  // ----------------------------------------

  always_comb begin
    state_nxt = state_q;
    pc_nxt    = pc_q;
    case (state_q)
      cpu_types_pkg::fetch_reset: begin
        // Address already parked on FFFE
        state_nxt = cpu_types_pkg::fetch_vec_hi;
      end
      cpu_types_pkg::fetch_vec_hi: begin
        state_nxt = cpu_types_pkg::fetch_vec_lo;
        pc_nxt    = pc_q + 1'b1;
      end
      cpu_types_pkg::fetch_vec_lo: begin
        // Big-endian vector, jump straight to it
        state_nxt = cpu_types_pkg::fetch_opcode;
        pc_nxt    = cpu_types_pkg::addr_t'({vec_hi_q, data_in});
      end
      cpu_types_pkg::fetch_opcode: begin
        // Hold address while halted
        if (halt_b) begin
          pc_nxt = pc_q + 1'b1;
        end
      end
      default: begin
        state_nxt = cpu_types_pkg::fetch_reset;
      end
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q       <= cpu_types_pkg::fetch_reset;
      pc_q          <= `CPU_RESET_VECTOR;
      issue_valid_q <= 1'b0;
    end else begin
      state_q       <= state_nxt;
      pc_q          <= pc_nxt;
      issue_valid_q <= take_opcode;
    end
  end

  // Payload bytes
  always_ff @(posedge clk) begin
    if (state_q == cpu_types_pkg::fetch_vec_hi) begin
      vec_hi_q <= data_in;
    end
    if (take_opcode) begin
      opcode_q <= data_in;
    end
  end

  assign addr  = pc_q;
  assign issue = '{valid: issue_valid_q, opcode: opcode_q};

  // Each issued opcode came from the address just before the current one
  a_addr_step: assert property (
    @(posedge clk) disable iff (!reset_b)
    issue.valid |-> (addr == cpu_types_pkg::addr_t'($past(addr) + 1'b1))
  ) else $error("addr did not step by one on an issuing cycle");

endmodule

// ==== src/accum_alu.sv ====
// Accumulator ALU and decode
module accum_alu (
  input  cpu_types_pkg::issue_t      issue,
  input  cpu_types_pkg::arch_state_t arch,
  output cpu_types_pkg::writeback_t  wb
);

  // Opcode rows for the two accumulators
  localparam logic [3:0] ROW_A = 4'h4;
  localparam logic [3:0] ROW_B = 4'h5;

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  m6809_isa_pkg::alu_op_t op;
  logic                   sel_a;
  logic                   sel_b;

  always_comb begin
    case (issue.opcode)
      m6809_isa_pkg::OP_CLRA, m6809_isa_pkg::OP_CLRB: op = m6809_isa_pkg::alu_clr;
      m6809_isa_pkg::OP_INCA, m6809_isa_pkg::OP_INCB: op = m6809_isa_pkg::alu_inc;
      m6809_isa_pkg::OP_COMA, m6809_isa_pkg::OP_COMB: op = m6809_isa_pkg::alu_com;
      m6809_isa_pkg::OP_ASLA, m6809_isa_pkg::OP_ASLB: op = m6809_isa_pkg::alu_asl;
      m6809_isa_pkg::OP_ASRA, m6809_isa_pkg::OP_ASRB: op = m6809_isa_pkg::alu_asr;
      m6809_isa_pkg::OP_LSRA, m6809_isa_pkg::OP_LSRB: op = m6809_isa_pkg::alu_lsr;
      default:                                        op = m6809_isa_pkg::alu_none;
    endcase
  end

  // High nibble picks source and destination
  assign sel_a = issue.opcode[7:4] == ROW_A;
  assign sel_b = issue.opcode[7:4] == ROW_B;

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  cpu_types_pkg::byte_t operand;
  cpu_types_pkg::byte_t result;
  logic                 flag_v;
  logic                 flag_c;
  m6809_isa_pkg::cc_t   cc_old;
  m6809_isa_pkg::cc_t   cc_new;

  assign operand = sel_b ? arch.b : arch.a;
  assign cc_old  = arch.cc;

  always_comb begin
    // V and C hold unless the op says otherwise
    result = operand;
    flag_v = cc_old[m6809_isa_pkg::CC_V];
    flag_c = cc_old[m6809_isa_pkg::CC_C];
    case (op)
      m6809_isa_pkg::alu_clr: begin
        result = '0;
        flag_v = 1'b0;
        flag_c = 1'b0;
      end
      m6809_isa_pkg::alu_inc: begin
        // Signed overflow only out of 7F
        result = operand + 1'b1;
        flag_v = operand == 8'h7F;
      end
      m6809_isa_pkg::alu_com: begin
        result = ~operand;
        flag_v = 1'b0;
        flag_c = 1'b1;
      end
      m6809_isa_pkg::alu_asl: begin
        result = {operand[6:0], 1'b0};
        flag_v = operand[7] ^ operand[6];
        flag_c = operand[7];
      end
      m6809_isa_pkg::alu_asr: begin
        // Sign bit replicated
        result = {operand[7], operand[7:1]};
        flag_c = operand[0];
      end
      m6809_isa_pkg::alu_lsr: begin
        result = {1'b0, operand[7:1]};
        flag_c = operand[0];
      end
      default: begin
        result = operand;
      end
    endcase
  end

  // ----------------------------------------
  // Condition codes
  // ----------------------------------------

  // Mask bits and H pass straight through
  always_comb begin
    cc_new[m6809_isa_pkg::CC_E] = cc_old[m6809_isa_pkg::CC_E];
    cc_new[m6809_isa_pkg::CC_F] = cc_old[m6809_isa_pkg::CC_F];
    cc_new[m6809_isa_pkg::CC_H] = cc_old[m6809_isa_pkg::CC_H];
    cc_new[m6809_isa_pkg::CC_I] = cc_old[m6809_isa_pkg::CC_I];
    // N and Z always follow the result
    cc_new[m6809_isa_pkg::CC_N] = result[7];
    cc_new[m6809_isa_pkg::CC_Z] = result == '0;
    cc_new[m6809_isa_pkg::CC_V] = flag_v;
    cc_new[m6809_isa_pkg::CC_C] = flag_c;
  end

  // Unknown opcodes leave everything alone
  assign wb.valid   = issue.valid;
  assign wb.opcode  = issue.opcode;
  assign wb.write_a = issue.valid && (op != m6809_isa_pkg::alu_none) && sel_a;
  assign wb.write_b = issue.valid && (op != m6809_isa_pkg::alu_none) && sel_b;
  assign wb.result  = result;
  assign wb.cc      = (op == m6809_isa_pkg::alu_none) ? cc_old : cc_new;

  // One accumulator per instruction
  always_comb begin
    a_one_dest: assert final (!(wb.write_a && wb.write_b))
      else $error("writeback targets both A and B");
  end

endmodule

// ==== src/accum_regfile.sv ====
// Accumulator registers and trace port
`include "cpu_cfg.svh"

module accum_regfile (
  input  logic                       clk,
  input  logic                       reset_b,
  input  cpu_types_pkg::writeback_t  wb,
  output cpu_types_pkg::arch_state_t arch,
  output cpu_types_pkg::trace_t      trace,
  output logic                       trace_valid
);

  // ----------------------------------------
  // Architectural state
  // ----------------------------------------

  cpu_types_pkg::byte_t a_q;
  cpu_types_pkg::byte_t b_q;
  m6809_isa_pkg::cc_t   cc_q;

  // Post-instruction values
  cpu_types_pkg::byte_t a_nxt;
  cpu_types_pkg::byte_t b_nxt;
  m6809_isa_pkg::cc_t   cc_nxt;

  assign a_nxt  = wb.write_a ? wb.result : a_q;
  assign b_nxt  = wb.write_b ? wb.result : b_q;
  assign cc_nxt = wb.valid ? wb.cc : cc_q;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= '0;
      b_q  <= '0;
      cc_q <= `CPU_CC_RESET;
    end else begin
      a_q  <= a_nxt;
      b_q  <= b_nxt;
      cc_q <= cc_nxt;
    end
  end

  assign arch = '{a: a_q, b: b_q, cc: cc_q};

  // ----------------------------------------
  // Retirement trace
  // ----------------------------------------

  cpu_types_pkg::trace_t trace_q;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= wb.valid;
    end
  end

  // Entry only captured on retirement
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      trace_q <= '{opcode: wb.opcode, a: a_nxt, b: b_nxt, cc: cc_nxt};
    end
  end

  assign trace = trace_q;

  // Vector fetch still under way, nothing can retire yet
  a_quiet_after_reset: assert property (
    @(posedge clk) $rose(reset_b) |=> !trace_valid
  ) else $error("trace_valid high right after reset release");

endmodule

// ==== src/core6809.sv ====
// 6809 accumulator core top level
module core6809 (
  input  logic                  clk,
  input  logic                  reset_b,
  input  logic                  halt_b,
  input  cpu_types_pkg::byte_t  data_in,
  output cpu_types_pkg::addr_t  addr,
  output cpu_types_pkg::trace_t trace,
  output logic                  trace_valid
);

  // ----------------------------------------
  // Internal paths
  // ----------------------------------------

  cpu_types_pkg::issue_t      issue;
  cpu_types_pkg::arch_state_t arch;
  cpu_types_pkg::writeback_t  wb;

  // Fetch side, owns the bus
  fetch_sequencer i_fetch_sequencer (
    .clk     (clk),
    .reset_b (reset_b),
    .halt_b  (halt_b),
    .data_in (data_in),
    .addr    (addr),
    .issue   (issue)
  );

  // Combinational execute
  accum_alu i_accum_alu (
    .issue (issue),
    .arch  (arch),
    .wb    (wb)
  );

  // Registers and trace
  accum_regfile i_accum_regfile (
    .clk         (clk),
    .reset_b     (reset_b),
    .wb          (wb),
    .arch        (arch),
    .trace       (trace),
    .trace_valid (trace_valid)
  );

endmodule

// ==== sim/core6809_tb.sv ====
// Accumulator core testbench
`include "cpu_cfg.svh"

module core6809_tb;

  // ----------------------------------------
  // Run constants
  // ----------------------------------------

  localparam int ROWS           = 32;
  localparam int TIMEOUT_CYCLES = ROWS * 4 + 20;
  localparam time DRIVE_DLY     = 10;
  localparam cpu_types_pkg::addr_t PROG_BASE = 16'h0100;

  logic                  clk;
  logic                  reset_b;
  logic                  halt_b;
  cpu_types_pkg::byte_t  data_in;
  cpu_types_pkg::addr_t  addr;
  cpu_types_pkg::trace_t trace;
  logic                  trace_valid;

  // Full 64K map, read only
  cpu_types_pkg::byte_t  mem [0:65535];
  // Opcode plus expected A, B and CC after it
  cpu_types_pkg::trace_t program_table [0:ROWS-1];

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          rows_seen;
  int          addr_errors;
  int          data_errors;
  int          cc_errors;
  int          seq_errors;
  logic        trace_done;

  core6809 i_core6809 (
    .clk         (clk),
    .reset_b     (reset_b),
    .halt_b      (halt_b),
    .data_in     (data_in),
    .addr        (addr),
    .trace       (trace),
    .trace_valid (trace_valid)
  );

  // Memory answers in the same cycle
  assign data_in = mem[addr];

  always #50 clk = ~clk;

  // Cycle budget
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d trace entries seen",
               cycle_count, rows_seen, ROWS);
      $display("Errors: addr %0d, data %0d, cc %0d, sequence %0d",
               addr_errors, data_errors, cc_errors, seq_errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_addr(input string name, input cpu_types_pkg::addr_t expected,
                            input cpu_types_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      addr_errors++;
    end
  endtask

  task automatic check_byte(input string name, input cpu_types_pkg::byte_t expected,
                            input cpu_types_pkg::byte_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      data_errors++;
    end
  endtask

  task automatic check_cc(input string name, input m6809_isa_pkg::cc_t expected,
                          input m6809_isa_pkg::cc_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      cc_errors++;
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // ----------------------------------------
  // Program and expected state
  // ----------------------------------------

  task automatic load_table();
    // Dependent pairs first, CC starts at D0
    program_table[0]  = {m6809_isa_pkg::OP_CLRA, 8'h00, 8'h00, 8'hD4};
    program_table[1]  = {m6809_isa_pkg::OP_INCA, 8'h01, 8'h00, 8'hD0};
    program_table[2]  = {m6809_isa_pkg::OP_ASLA, 8'h02, 8'h00, 8'hD0};
    program_table[3]  = {m6809_isa_pkg::OP_INCB, 8'h02, 8'h01, 8'hD0};
    program_table[4]  = {m6809_isa_pkg::OP_COMB, 8'h02, 8'hFE, 8'hD9};
    // Unknown opcode retires as no-op
    program_table[5]  = {8'h12,                  8'h02, 8'hFE, 8'hD9};
    program_table[6]  = {m6809_isa_pkg::OP_ASLA, 8'h04, 8'hFE, 8'hD0};
    program_table[7]  = {m6809_isa_pkg::OP_CLRA, 8'h00, 8'hFE, 8'hD4};
    program_table[8]  = {m6809_isa_pkg::OP_COMA, 8'hFF, 8'hFE, 8'hD9};
    program_table[9]  = {m6809_isa_pkg::OP_LSRA, 8'h7F, 8'hFE, 8'hD1};
    // INC of 7F sets V, C carried over
    program_table[10] = {m6809_isa_pkg::OP_INCA, 8'h80, 8'hFE, 8'hDB};
    program_table[11] = {m6809_isa_pkg::OP_ASLA, 8'h00, 8'hFE, 8'hD7};
    program_table[12] = {m6809_isa_pkg::OP_COMA, 8'hFF, 8'hFE, 8'hD9};
    program_table[13] = {m6809_isa_pkg::OP_ASLA, 8'hFE, 8'hFE, 8'hD9};
    program_table[14] = {m6809_isa_pkg::OP_ASRA, 8'hFF, 8'hFE, 8'hD8};
    program_table[15] = {m6809_isa_pkg::OP_LSRB, 8'hFF, 8'h7F, 8'hD0};
    // Second half runs with random halts
    program_table[16] = {8'h12,                  8'hFF, 8'h7F, 8'hD0};
    program_table[17] = {m6809_isa_pkg::OP_INCB, 8'hFF, 8'h80, 8'hDA};
    program_table[18] = {m6809_isa_pkg::OP_LSRB, 8'hFF, 8'h40, 8'hD2};
    program_table[19] = {m6809_isa_pkg::OP_ASRA, 8'hFF, 8'h40, 8'hDB};
    program_table[20] = {m6809_isa_pkg::OP_CLRB, 8'hFF, 8'h00, 8'hD4};
    program_table[21] = {m6809_isa_pkg::OP_LSRA, 8'h7F, 8'h00, 8'hD1};
    program_table[22] = {m6809_isa_pkg::OP_ASLB, 8'h7F, 8'h00, 8'hD4};
    program_table[23] = {m6809_isa_pkg::OP_INCA, 8'h80, 8'h00, 8'hDA};
    program_table[24] = {m6809_isa_pkg::OP_ASRA, 8'hC0, 8'h00, 8'hDA};
    program_table[25] = {m6809_isa_pkg::OP_ASRB, 8'hC0, 8'h00, 8'hD6};
    program_table[26] = {m6809_isa_pkg::OP_INCA, 8'hC1, 8'h00, 8'hD8};
    program_table[27] = {m6809_isa_pkg::OP_CLRB, 8'hC1, 8'h00, 8'hD4};
    program_table[28] = {m6809_isa_pkg::OP_COMB, 8'hC1, 8'hFF, 8'hD9};
    program_table[29] = {8'h13,                  8'hC1, 8'hFF, 8'hD9};
    program_table[30] = {m6809_isa_pkg::OP_LSRA, 8'h60, 8'hFF, 8'hD1};
    program_table[31] = {m6809_isa_pkg::OP_ASLA, 8'hC0, 8'hFF, 8'hDA};
  endtask

  task automatic load_memory();
    // Background pattern from both address bytes
    for (int i = 0; i < 65536; i++) begin
      mem[i] = cpu_types_pkg::byte_t'(i[15:8] ^ i[7:0] ^ 8'hA5);
    end
    mem[`CPU_RESET_VECTOR]     = PROG_BASE[15:8];
    mem[`CPU_RESET_VECTOR + 1] = PROG_BASE[7:0];
    for (int k = 0; k < ROWS; k++) begin
      mem[PROG_BASE + k] = program_table[k].opcode;
    end
  endtask

  // ----------------------------------------
  // Fetch side, halt_b and address checks
  // ----------------------------------------

  task automatic drive_fetch();
    cpu_types_pkg::addr_t expected_pc;
    logic                 bit0;
    logic                 bit1;
    // Two vector reads at FFFE, then FFFF
    while (addr === `CPU_RESET_VECTOR) begin
      @(negedge clk);
      if (trace_valid !== 1'b0) begin
        $display("trace_valid went high during the vector fetch");
        seq_errors++;
      end
    end
    check_addr("vector low address", `CPU_RESET_VECTOR + 1, addr);
    expected_pc = PROG_BASE;
    while (!trace_done) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (expected_pc >= PROG_BASE + ROWS) begin
        // Park past the program
        halt_b = 1'b0;
      end else if (expected_pc >= PROG_BASE + ROWS / 2) begin
        lfsr_state = lfsr_next(lfsr_state);
        bit0       = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bit1       = lfsr_state[0];
        halt_b     = bit0 | bit1;
      end else begin
        halt_b = 1'b1;
      end
      @(negedge clk);
      check_addr("fetch address", expected_pc, addr);
      if (expected_pc == PROG_BASE && trace_valid !== 1'b0) begin
        $display("trace_valid high before the first opcode retired");
        seq_errors++;
      end
      // Address holds while halted
      if (halt_b) begin
        expected_pc = expected_pc + 1'b1;
      end
    end
  endtask

  // ----------------------------------------
  // Trace collection
  // ----------------------------------------

  task automatic collect_trace();
    while (rows_seen < ROWS) begin
      @(negedge clk);
      if (trace_valid === 1'b1) begin
        check_byte($sformatf("row %0d opcode", rows_seen),
                   program_table[rows_seen].opcode, trace.opcode);
        check_byte($sformatf("row %0d A", rows_seen), program_table[rows_seen].a, trace.a);
        check_byte($sformatf("row %0d B", rows_seen), program_table[rows_seen].b, trace.b);
        check_cc($sformatf("row %0d CC", rows_seen), program_table[rows_seen].cc, trace.cc);
        rows_seen++;
      end
    end
    // Fetch is parked, nothing more may retire
    repeat (8) begin
      @(negedge clk);
      if (trace_valid !== 1'b0) begin
        $display("Extra trace entry after the last program row, opcode %h", trace.opcode);
        seq_errors++;
      end
    end
    trace_done = 1'b1;
  endtask

  initial begin
    clk         = 1'b0;
    reset_b     = 1'b0;
    halt_b      = 1'b1;
    lfsr_state  = 32'h4e01_5a9e;
    cycle_count = 0;
    rows_seen   = 0;
    addr_errors = 0;
    data_errors = 0;
    cc_errors   = 0;
    seq_errors  = 0;
    trace_done  = 1'b0;
    load_table();
    load_memory();
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_addr("reset address", `CPU_RESET_VECTOR, addr);
    if (trace_valid !== 1'b0) begin
      $display("trace_valid high while reset_b is low");
      seq_errors++;
    end
    @(posedge clk);
    #DRIVE_DLY;
    reset_b = 1'b1;
    fork
      drive_fetch();
      collect_trace();
    join
    $display("Errors: addr %0d, data %0d, cc %0d, sequence %0d",
             addr_errors, data_errors, cc_errors, seq_errors);
    if (addr_errors + data_errors + cc_errors + seq_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/cpu_types_pkg.sv
src/m6809_isa_pkg.sv
src/fetch_sequencer.sv
src/accum_alu.sv
src/accum_regfile.sv
src/core6809.sv
sim/core6809_tb.sv

// ==== Bender.yml ====
package:
  name: core6809

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_types_pkg.sv
      - src/m6809_isa_pkg.sv
      - src/fetch_sequencer.sv
      - src/accum_alu.sv
      - src/accum_regfile.sv
      - src/core6809.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/core6809_tb.sv
